// File: hw/fpu_pkg.sv
// ==============================
// FPU iterative-unit package
// Single-precision format constants, vector types,
// flag positions and the shared state enum
// ==============================
package fpu_pkg;

  // ==============================
  // Format
  // ==============================
  localparam int FLEN      = 32;
  localparam int EXP_WIDTH = 8;
  localparam int MAN_WIDTH = 23;
  localparam int BIAS      = 127;
  localparam int EXP_MAX   = 255;              // All-ones exponent, inf and NaN
  localparam int ROOT_BITS = MAN_WIDTH + 4;    // Hidden 1, mantissa, guard, round, sticky

  typedef logic [FLEN-1:0] fp_word_t;          // One IEEE single value
  typedef logic [2:0]      frm_t;              // RISC-V rounding mode
  typedef logic [4:0]      fflags_t;           // NV DZ OF UF NX
  typedef logic [0:0]      unit_id_t;          // Writeback tag

  localparam fp_word_t CANON_NAN = 32'h7FC0_0000;

  // Rounding modes, anything above RMM acts like RTZ
  localparam frm_t FRM_RNE = 3'd0;
  localparam frm_t FRM_RTZ = 3'd1;
  localparam frm_t FRM_RDN = 3'd2;
  localparam frm_t FRM_RUP = 3'd3;
  localparam frm_t FRM_RMM = 3'd4;

  // Bit positions in fflags_t
  localparam int FLAG_NV = 4;
  localparam int FLAG_DZ = 3;
  localparam int FLAG_OF = 2;
  localparam int FLAG_UF = 1;
  localparam int FLAG_NX = 0;

  localparam unit_id_t UNIT_SQRT = 1'b0;
  localparam unit_id_t UNIT_DIV  = 1'b1;

  // Shared by sqrt and div
  typedef enum logic [2:0] {
    IDLE,
    UNPACK,
    COMPUTE,
    ROUND,
    WRITEBACK
  } iter_state_t;

endpackage

// File: hw/fp_sqrt.sv
// ==============================
// Single-precision square root
// Radix-2 digit recurrence, one root bit per cycle,
// IEEE rounding and a four-phase writeback request
// ==============================
module fp_sqrt (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              start,
  input  fpu_pkg::frm_t     frm,
  input  fpu_pkg::fp_word_t operand,
  output logic              busy,
  output logic              wb_req,
  input  logic              wb_ack,
  output fpu_pkg::fp_word_t wb_data,
  output fpu_pkg::fflags_t  wb_flags
);
  import fpu_pkg::*;

  iter_state_t state;
  fp_word_t    op_q;                       // Operand captured at start
  frm_t        frm_q;
  logic [4:0]  cnt;                        // Check cycle plus ROOT_BITS steps

  // Special-value decode
  logic is_nan, is_inf, is_zero, is_neg;
  logic special;
  logic check_cyc;                         // First COMPUTE cycle

  // Recurrence
  logic [EXP_WIDTH-1:0]   op_exp;
  logic [EXP_WIDTH:0]     exp_sum;         // Biased exponent plus even adjust
  logic [EXP_WIDTH-1:0]   res_exp;
  logic [2*ROOT_BITS-1:0] rad;             // Radicand, two bits per step off the top
  logic [ROOT_BITS-1:0]   root;
  logic [ROOT_BITS+3:0]   rem;             // Partial remainder
  logic [ROOT_BITS+3:0]   rem_sh;
  logic [ROOT_BITS+3:0]   trial;           // 4*root + 1
  logic                   step_ok;

  // Rounding
  logic     guard_b, round_b, sticky_b;
  logic     inexact, round_up;
  fp_word_t rounded;

  assign busy      = (state != IDLE);
  assign op_exp    = op_q[FLEN-2:MAN_WIDTH];
  assign special   = is_nan | is_inf | is_zero | is_neg;
  assign check_cyc = (cnt == 5'(ROOT_BITS + 1));

  // Even exponent: odd biased values keep the radicand, even ones shift it
  assign exp_sum = {1'b0, op_exp} + (EXP_WIDTH+1)'(BIAS - 1) + (EXP_WIDTH+1)'(op_exp[0]);

  // ==============================
  // Recurrence step
  // ==============================
  always_comb begin
    rem_sh  = {rem[ROOT_BITS+1:0], rad[2*ROOT_BITS-1 -: 2]};  // Bring down next pair
    trial   = {2'b00, root, 2'b01};
    step_ok = (rem_sh >= trial);                              // Root bit is 1
  end

  // Root is always positive, so RDN never rounds up and RUP does on any loss
  assign guard_b  = root[2];
  assign round_b  = root[1];
  assign sticky_b = root[0] | (rem != '0);
  assign inexact  = guard_b | round_b | sticky_b;

  always_comb begin
    case (frm_q)
      FRM_RNE:          round_up = guard_b & (round_b | sticky_b | root[3]);
      FRM_RUP:          round_up = inexact;
      FRM_RMM:          round_up = guard_b;
      FRM_RTZ, FRM_RDN: round_up = 1'b0;
      default:          round_up = 1'b0;
    endcase
  end

  // Mantissa carry ripples into the exponent field
  assign rounded = {1'b0, res_exp, root[ROOT_BITS-2:3]} + FLEN'(round_up);

  // ==============================
  // Control FSM
  // ==============================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state  <= IDLE;
      cnt    <= '0;
      wb_req <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) state <= UNPACK;
        end
        UNPACK: begin
          cnt   <= 5'(ROOT_BITS + 1);
          state <= COMPUTE;
        end
        COMPUTE: begin
          cnt <= cnt - 5'd1;
          if ((check_cyc && special) || cnt == 5'd1) state <= ROUND;  // Specials skip steps
        end
        ROUND: begin
          wb_req <= 1'b1;
          state  <= WRITEBACK;
        end
        WRITEBACK: begin
          if (wb_req && wb_ack) begin
            wb_req <= 1'b0;                          // Ack seen, release
          end else if (!wb_req && !wb_ack) begin
            state <= IDLE;                           // Handshake closed
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ==============================
  // Datapath
  // ==============================
  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      op_q  <= operand;
      frm_q <= frm;
    end
    case (state)
      UNPACK: begin
        is_nan  <= (op_exp == EXP_WIDTH'(EXP_MAX)) && (op_q[MAN_WIDTH-1:0] != '0);
        is_inf  <= (op_exp == EXP_WIDTH'(EXP_MAX)) && (op_q[MAN_WIDTH-1:0] == '0);
        is_zero <= (op_exp == '0);                   // Subnormals flush to zero
        is_neg  <= op_q[FLEN-1] && (op_exp != '0);
        res_exp <= exp_sum[EXP_WIDTH:1];
        if (op_exp[0])
          rad <= {2'b01, op_q[MAN_WIDTH-1:0], {(2*ROOT_BITS-MAN_WIDTH-2){1'b0}}};
        else
          rad <= {1'b1, op_q[MAN_WIDTH-1:0], {(2*ROOT_BITS-MAN_WIDTH-1){1'b0}}};
        root <= '0;
        rem  <= '0;
      end
      COMPUTE: begin
        if (check_cyc) begin
          wb_flags <= '0;
          if (is_nan) begin
            wb_data <= CANON_NAN;
          end else if (is_zero) begin
            wb_data <= {op_q[FLEN-1], {(FLEN-1){1'b0}}};   // Keeps sign of zero
          end else if (is_neg) begin
            wb_data  <= CANON_NAN;
            wb_flags <= fflags_t'(1 << FLAG_NV);
          end else if (is_inf) begin
            wb_data <= {1'b0, EXP_WIDTH'(EXP_MAX), {MAN_WIDTH{1'b0}}};
          end
        end else begin
          rad  <= rad << 2;
          root <= {root[ROOT_BITS-2:0], step_ok};
          rem  <= step_ok ? (rem_sh - trial) : rem_sh;
        end
      end
      ROUND: begin
        if (!special) begin
          wb_data  <= rounded;
          wb_flags <= inexact ? fflags_t'(1 << FLAG_NX) : '0;
        end
      end
      default: ;
    endcase
  end

endmodule

// File: hw/fp_div.sv
// ==============================
// Single-precision divider
// Restoring recurrence, one quotient bit per cycle,
// IEEE rounding, range checks and writeback request
// ==============================
module fp_div (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              start,
  input  fpu_pkg::frm_t     frm,
  input  fpu_pkg::fp_word_t dividend,
  input  fpu_pkg::fp_word_t divisor,
  output logic              busy,
  output logic              wb_req,
  input  logic              wb_ack,
  output fpu_pkg::fp_word_t wb_data,
  output fpu_pkg::fflags_t  wb_flags
);
  import fpu_pkg::*;

  iter_state_t state;
  fp_word_t    a_q, b_q;                   // Operands captured at start
  frm_t        frm_q;
  logic [4:0]  cnt;
  logic        check_cyc;

  // Unpacked fields
  logic [EXP_WIDTH-1:0] ea, eb;
  logic                 sign_q;
  logic                 a_nan, a_inf, a_zero;
  logic                 b_nan, b_inf, b_zero;
  logic                 invalid, special;

  // Recurrence
  logic [EXP_WIDTH+1:0] exp_d;             // Signed, biased quotient exponent
  logic [MAN_WIDTH:0]   mb;                // Divisor mantissa with hidden 1
  logic [MAN_WIDTH+2:0] rem;
  logic [MAN_WIDTH+2:0] diff;
  logic                 step_ok;
  logic [ROOT_BITS-1:0] q;

  // Normalize and round
  logic                           norm;    // Quotient already in [1,2)
  logic [MAN_WIDTH:0]             man;
  logic                           guard_b, round_b, sticky_b, inexact;
  logic                           round_up, max_fin;
  logic [EXP_WIDTH+1:0]           exp_adj;
  logic [EXP_WIDTH+MAN_WIDTH+1:0] sum;     // {exponent, fraction} after rounding
  logic [EXP_WIDTH+1:0]           exp_r;
  logic                           ovf, unf;

  assign busy      = (state != IDLE);
  assign ea        = a_q[FLEN-2:MAN_WIDTH];
  assign eb        = b_q[FLEN-2:MAN_WIDTH];
  assign check_cyc = (cnt == 5'(ROOT_BITS + 1));
  assign invalid   = a_nan | b_nan | (a_zero & b_zero) | (a_inf & b_inf);
  assign special   = a_nan | b_nan | a_inf | b_inf | a_zero | b_zero;

  // Trial subtract, top bit is the borrow
  assign diff    = rem - {2'b00, mb};
  assign step_ok = !diff[MAN_WIDTH+2];

  // ==============================
  // Normalize, round, range
  // ==============================
  always_comb begin
    norm     = q[ROOT_BITS-1];
    man      = norm ? q[ROOT_BITS-1:3] : q[ROOT_BITS-2:2];   // Last step fills the gap
    guard_b  = norm ? q[2] : q[1];
    round_b  = norm ? q[1] : q[0];
    sticky_b = (norm & q[0]) | (rem != '0);
    inexact  = guard_b | round_b | sticky_b;

    case (frm_q)
      FRM_RNE: round_up = guard_b & (round_b | sticky_b | man[0]);
      FRM_RTZ: round_up = 1'b0;
      FRM_RDN: round_up = sign_q & inexact;
      FRM_RUP: round_up = !sign_q & inexact;
      FRM_RMM: round_up = guard_b;
      default: round_up = 1'b0;
    endcase

    // Overflow saturates when rounding toward zero
    case (frm_q)
      FRM_RNE, FRM_RMM: max_fin = 1'b0;
      FRM_RDN:          max_fin = !sign_q;
      FRM_RUP:          max_fin = sign_q;
      default:          max_fin = 1'b1;
    endcase

    exp_adj = exp_d - (EXP_WIDTH+2)'(!norm);
    sum     = {exp_adj, man[MAN_WIDTH-1:0]} + (EXP_WIDTH+MAN_WIDTH+2)'(round_up);
    exp_r   = sum[EXP_WIDTH+MAN_WIDTH+1:MAN_WIDTH];
    ovf     = ($signed(exp_r) >= EXP_MAX);
    unf     = ($signed(exp_r) <= 0);          // No subnormal results
  end

  // ==============================
  // Control FSM
  // ==============================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state  <= IDLE;
      cnt    <= '0;
      wb_req <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) state <= UNPACK;
        end
        UNPACK: begin
          cnt   <= 5'(ROOT_BITS + 1);
          state <= COMPUTE;
        end
        COMPUTE: begin
          cnt <= cnt - 5'd1;
          if ((check_cyc && special) || cnt == 5'd1) state <= ROUND;
        end
        ROUND: begin
          wb_req <= 1'b1;
          state  <= WRITEBACK;
        end
        WRITEBACK: begin
          if (wb_req && wb_ack)
            wb_req <= 1'b0;
          else if (!wb_req && !wb_ack)
            state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ==============================
  // Datapath
  // ==============================
  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      a_q   <= dividend;
      b_q   <= divisor;
      frm_q <= frm;
    end
    case (state)
      UNPACK: begin
        sign_q <= a_q[FLEN-1] ^ b_q[FLEN-1];
        a_nan  <= (ea == EXP_WIDTH'(EXP_MAX)) && (a_q[MAN_WIDTH-1:0] != '0);
        a_inf  <= (ea == EXP_WIDTH'(EXP_MAX)) && (a_q[MAN_WIDTH-1:0] == '0);
        a_zero <= (ea == '0);                        // Subnormal counts as zero
        b_nan  <= (eb == EXP_WIDTH'(EXP_MAX)) && (b_q[MAN_WIDTH-1:0] != '0);
        b_inf  <= (eb == EXP_WIDTH'(EXP_MAX)) && (b_q[MAN_WIDTH-1:0] == '0);
        b_zero <= (eb == '0);
        exp_d  <= {2'b00, ea} - {2'b00, eb} + (EXP_WIDTH+2)'(BIAS);
        mb     <= {1'b1, b_q[MAN_WIDTH-1:0]};
        rem    <= {3'b001, a_q[MAN_WIDTH-1:0]};      // Dividend mantissa
        q      <= '0;
      end
      COMPUTE: begin
        if (check_cyc) begin
          wb_flags <= '0;
          if (invalid) begin
            wb_data  <= CANON_NAN;
            wb_flags <= fflags_t'(1 << FLAG_NV);
          end else if (a_inf) begin
            wb_data <= {sign_q, EXP_WIDTH'(EXP_MAX), {MAN_WIDTH{1'b0}}};
          end else if (b_zero) begin
            wb_data  <= {sign_q, EXP_WIDTH'(EXP_MAX), {MAN_WIDTH{1'b0}}};
            wb_flags <= fflags_t'(1 << FLAG_DZ);
          end else if (b_inf || a_zero) begin
            wb_data <= {sign_q, {(FLEN-1){1'b0}}};
          end
        end else begin
          q   <= {q[ROOT_BITS-2:0], step_ok};
          rem <= step_ok ? {diff[MAN_WIDTH+1:0], 1'b0} : {rem[MAN_WIDTH+1:0], 1'b0};
        end
      end
      ROUND: begin
        if (!special) begin
          if (ovf) begin
            wb_data <= max_fin ?
                       {sign_q, EXP_WIDTH'(EXP_MAX - 1), {MAN_WIDTH{1'b1}}} :
                       {sign_q, EXP_WIDTH'(EXP_MAX), {MAN_WIDTH{1'b0}}};
            wb_flags <= fflags_t'((1 << FLAG_OF) | (1 << FLAG_NX));
          end else if (unf) begin
            wb_data  <= {sign_q, {(FLEN-1){1'b0}}};
            wb_flags <= fflags_t'((1 << FLAG_UF) | (1 << FLAG_NX));
          end else begin
            wb_data  <= {sign_q, exp_r[EXP_WIDTH-1:0], sum[MAN_WIDTH-1:0]};
            wb_flags <= inexact ? fflags_t'(1 << FLAG_NX) : '0;
          end
        end
      end
      default: ;
    endcase
  end

endmodule

// File: hw/wb_arbiter.sv
// ==============================
// Writeback arbiter
// Round-robin grant of the shared bus, four-phase req/ack
// ==============================
module wb_arbiter (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                sqrt_req,
  output logic                sqrt_ack,
  input  fpu_pkg::fp_word_t   sqrt_data,
  input  fpu_pkg::fflags_t    sqrt_flags,
  input  logic                div_req,
  output logic                div_ack,
  input  fpu_pkg::fp_word_t   div_data,
  input  fpu_pkg::fflags_t    div_flags,
  output logic                wb_valid,
  output fpu_pkg::unit_id_t   wb_unit,
  output fpu_pkg::fp_word_t   wb_data,
  output fpu_pkg::fflags_t    wb_flags
);
  import fpu_pkg::*;

  logic     active;                        // Handshake open
  unit_id_t owner;                         // Unit holding the ack
  unit_id_t rr;                            // Favored unit on a tie
  unit_id_t grant;
  logic     any_req;
  logic     owner_req;

  assign any_req   = sqrt_req | div_req;
  assign owner_req = (owner == UNIT_DIV) ? div_req : sqrt_req;

  always_comb begin
    if (sqrt_req && div_req) grant = rr;
    else if (div_req)        grant = UNIT_DIV;
    else                     grant = UNIT_SQRT;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      active   <= 1'b0;
      owner    <= UNIT_SQRT;
      rr       <= UNIT_SQRT;
      sqrt_ack <= 1'b0;
      div_ack  <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= 1'b0;                    // Single-cycle pulse
      if (!active) begin
        if (any_req) begin
          active   <= 1'b1;
          owner    <= grant;
          rr       <= ~grant;              // Loser goes first next time
          sqrt_ack <= (grant == UNIT_SQRT);
          div_ack  <= (grant == UNIT_DIV);
          wb_valid <= 1'b1;
        end
      end else if (!owner_req) begin
        active   <= 1'b0;                  // Req fell, close the cycle
        sqrt_ack <= 1'b0;
        div_ack  <= 1'b0;
      end
    end
  end

  // Bus payload, sampled with the grant
  always_ff @(posedge clk) begin
    if (!active && any_req) begin
      wb_unit  <= grant;
      wb_data  <= (grant == UNIT_DIV) ? div_data  : sqrt_data;
      wb_flags <= (grant == UNIT_DIV) ? div_flags : sqrt_flags;
    end
  end

endmodule

// File: hw/fpu_iter_top.sv
// ==============================
// FPU iterative units top
// Sqrt and div sharing one writeback bus
// ==============================
module fpu_iter_top (
  input  logic              clk,
  input  logic              reset_n,
  input  fpu_pkg::frm_t     frm,
  input  logic              sqrt_start,
  input  fpu_pkg::fp_word_t sqrt_a,
  output logic              sqrt_busy,
  input  logic              div_start,
  input  fpu_pkg::fp_word_t div_a,
  input  fpu_pkg::fp_word_t div_b,
  output logic              div_busy,
  output logic              wb_valid,
  output fpu_pkg::unit_id_t wb_unit,
  output fpu_pkg::fp_word_t wb_data,
  output fpu_pkg::fflags_t  wb_flags
);
  import fpu_pkg::*;

  // Unit to arbiter handshakes
  logic     sqrt_req, sqrt_ack;
  fp_word_t sqrt_data;
  fflags_t  sqrt_flags;
  logic     div_req, div_ack;
  fp_word_t div_data;
  fflags_t  div_flags;

  fp_sqrt i_fp_sqrt (
    .clk      (clk),
    .reset_n  (reset_n),
    .start    (sqrt_start),
    .frm      (frm),
    .operand  (sqrt_a),
    .busy     (sqrt_busy),
    .wb_req   (sqrt_req),
    .wb_ack   (sqrt_ack),
    .wb_data  (sqrt_data),
    .wb_flags (sqrt_flags)
  );

  fp_div i_fp_div (
    .clk      (clk),
    .reset_n  (reset_n),
    .start    (div_start),
    .frm      (frm),
    .dividend (div_a),
    .divisor  (div_b),
    .busy     (div_busy),
    .wb_req   (div_req),
    .wb_ack   (div_ack),
    .wb_data  (div_data),
    .wb_flags (div_flags)
  );

  wb_arbiter i_wb_arbiter (
    .clk        (clk),
    .reset_n    (reset_n),
    .sqrt_req   (sqrt_req),
    .sqrt_ack   (sqrt_ack),
    .sqrt_data  (sqrt_data),
    .sqrt_flags (sqrt_flags),
    .div_req    (div_req),
    .div_ack    (div_ack),
    .div_data   (div_data),
    .div_flags  (div_flags),
    .wb_valid   (wb_valid),
    .wb_unit    (wb_unit),
    .wb_data    (wb_data),
    .wb_flags   (wb_flags)
  );

endmodule

// File: sim/tb_fpu_ref.svh
// ==============================
// FPU reference models
// Integer square root and long division with IEEE rounding
// ==============================
`ifndef TB_FPU_REF_SVH
`define TB_FPU_REF_SVH

// One-hot flag word
function automatic fflags_t flag_mask(int idx);
  return fflags_t'(1 << idx);
endfunction

// Round-up decision, sign is 0 for a square root
function automatic logic round_inc(frm_t rm, logic sign, logic lsb, logic g, logic r, logic s);
  logic lost;
  lost = g | r | s;
  case (rm)
    FRM_RNE: round_inc = g & (r | s | lsb);      // Ties to even
    FRM_RDN: round_inc = sign & lost;
    FRM_RUP: round_inc = !sign & lost;
    FRM_RMM: round_inc = g;                      // Ties away
    default: round_inc = 1'b0;                   // RTZ and unused codes
  endcase
endfunction

// ==============================
// Square root, returns {flags, word}
// ==============================
function automatic logic [36:0] ref_sqrt(fp_word_t a, frm_t rm);
  int       e, b, exp_r;
  longint   x, r, t;
  logic     g, rb, s, up;
  fp_word_t res;
  e = int'(a[30:23]);
  if (e == 255 && a[22:0] != '0) return {fflags_t'(0), CANON_NAN};
  if (e == 0) return {fflags_t'(0), a[31], 31'h0};     // Zero or flushed subnormal
  if (a[31]) return {flag_mask(FLAG_NV), CANON_NAN};
  if (e == 255) return {fflags_t'(0), 32'h7F80_0000};
  // Odd biased exponent is an even true exponent, radicand stays in [1,2)
  x = longint'({1'b1, a[22:0]}) << (e[0] ? 29 : 30);
  r = 0;
  for (b = 26; b >= 0; b--) begin
    t = r | (longint'(1) << b);                  // Try this bit, keep it if square fits
    if (t * t <= x) r = t;
  end
  g     = r[2];
  rb    = r[1];
  s     = r[0] | (r * r != x);
  up    = round_inc(rm, 1'b0, r[3], g, rb, s);
  exp_r = (e + 127) / 2;                         // Halved true exponent, rebiased
  res   = {1'b0, exp_r[7:0], r[25:3]} + fp_word_t'(up);
  return {(g | rb | s) ? flag_mask(FLAG_NX) : fflags_t'(0), res};
endfunction

// ==============================
// Division, returns {flags, word}
// ==============================
function automatic logic [36:0] ref_div(fp_word_t a, fp_word_t b, frm_t rm);
  int          ea, eb, exp_r, frac;
  logic        sn, a_nan, b_nan, a_inf, b_inf, a_zero, b_zero;
  longint      num, den, q, rmd;
  logic [23:0] man;
  logic        norm, g, rb, s, up, lost, sat;
  fp_word_t    inf_w, zero_w;
  ea     = int'(a[30:23]);
  eb     = int'(b[30:23]);
  sn     = a[31] ^ b[31];
  a_nan  = (ea == 255) && (a[22:0] != '0);
  b_nan  = (eb == 255) && (b[22:0] != '0);
  a_inf  = (ea == 255) && (a[22:0] == '0);
  b_inf  = (eb == 255) && (b[22:0] == '0);
  a_zero = (ea == 0);
  b_zero = (eb == 0);
  inf_w  = {sn, 8'hFF, 23'h0};
  zero_w = {sn, 31'h0};
  if (a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf))
    return {flag_mask(FLAG_NV), CANON_NAN};
  if (a_inf) return {fflags_t'(0), inf_w};
  if (b_zero) return {flag_mask(FLAG_DZ), inf_w};
  if (b_inf || a_zero) return {fflags_t'(0), zero_w};
  num  = longint'({1'b1, a[22:0]}) << 26;        // 27 quotient bits
  den  = longint'({1'b1, b[22:0]});
  q    = num / den;
  rmd  = num % den;
  norm = q[26];                                  // Quotient in [1,2)
  man  = norm ? q[26:3] : q[25:2];
  g    = norm ? q[2] : q[1];
  rb   = norm ? q[1] : q[0];
  s    = (norm & q[0]) | (rmd != '0);
  lost = g | rb | s;
  up   = round_inc(rm, sn, man[0], g, rb, s);
  frac = int'(man[22:0]) + int'(up);
  exp_r = ea - eb + 127 - int'(!norm) + (frac >> 23);  // Carry out of the fraction
  frac  = frac & 32'h007F_FFFF;
  if (exp_r >= 255) begin
    case (rm)
      FRM_RNE, FRM_RMM: sat = 1'b0;
      FRM_RDN:          sat = !sn;
      FRM_RUP:          sat = sn;
      default:          sat = 1'b1;              // Toward zero
    endcase
    return {flag_mask(FLAG_OF) | flag_mask(FLAG_NX),
            sat ? {sn, 8'hFE, 23'h7F_FFFF} : inf_w};
  end
  if (exp_r <= 0) return {flag_mask(FLAG_UF) | flag_mask(FLAG_NX), zero_w};
  return {lost ? flag_mask(FLAG_NX) : fflags_t'(0), sn, exp_r[7:0], frac[22:0]};
endfunction

`endif

// File: sim/tb_fpu_iter.sv
// ==============================
// FPU iterative units testbench
// Random and directed sqrt/div, contention and busy checks
// ==============================
module tb_fpu_iter;
  import fpu_pkg::*;

  `include "tb_fpu_ref.svh"

  // Ops issued below, sizes the watchdog
  localparam int N_OPS      = 200 + 5 * (2 * 100 + 4) + 8 + 8 + 5 * 5 + 4 * 50 + 2;
  localparam int WATCH_TIME = (N_OPS * 64 + 8) * 8;

  localparam fp_word_t SQRT_SPECIAL [8] = '{32'h7F80_0001, 32'hFFC0_0000, 32'hC080_0000,
                                            32'hFF80_0000, 32'h7F80_0000, 32'h0000_0000,
                                            32'h8000_0000, 32'h0000_0001};
  localparam fp_word_t DIV_SPECIAL_A [8] = '{32'h3F80_0000, 32'hBF80_0000, 32'h0000_0000,
                                             32'h7F80_0000, 32'h4000_0000, 32'hFF80_0000,
                                             32'h0000_0000, 32'h7FC0_0000};
  localparam fp_word_t DIV_SPECIAL_B [8] = '{32'h0000_0000, 32'h0000_0000, 32'h0000_0000,
                                             32'hFF80_0000, 32'h7F80_0000, 32'h4000_0000,
                                             32'h40A0_0000, 32'h3F80_0000};

  logic        clk, reset_n;
  frm_t        frm;
  logic        sqrt_start, div_start;
  fp_word_t    sqrt_a, div_a, div_b;
  logic        sqrt_busy, div_busy;
  logic        wb_valid;
  unit_id_t    wb_unit;
  fp_word_t    wb_data;
  fflags_t     wb_flags;
  integer      seed;
  logic [37:0] exp_sqrt [$];              // {unit, flags, word}
  logic [37:0] exp_div [$];
  logic [37:0] want;
  logic        div_hit, sqrt_hit;
  int          mi, sg, k, off;

  fpu_iter_top i_fpu_iter_top (
    .clk(clk), .reset_n(reset_n), .frm(frm),
    .sqrt_start(sqrt_start), .sqrt_a(sqrt_a), .sqrt_busy(sqrt_busy),
    .div_start(div_start), .div_a(div_a), .div_b(div_b), .div_busy(div_busy),
    .wb_valid(wb_valid), .wb_unit(wb_unit), .wb_data(wb_data), .wb_flags(wb_flags)
  );

  always #4 clk = ~clk;

  task automatic stop_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(fp_word_t got, fp_word_t exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flags(fflags_t got, fflags_t exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_unit(unit_id_t got, unit_id_t exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
      stop_run();
    end
  endtask

  // Random normal operand, exponent 1..254
  function automatic fp_word_t rand_normal(logic any_sign);
    logic        s;
    logic [7:0]  e;
    logic [22:0] m;
    s = any_sign & 1'($random(seed));
    e = 8'(1 + ($unsigned($random(seed)) % 254));
    m = 23'($random(seed));
    return {s, e, m};
  endfunction

  // Busy sampled mid-cycle, stable there
  task automatic wait_free(logic for_sqrt, logic for_div);
    @(negedge clk);
    while ((for_sqrt && sqrt_busy) || (for_div && div_busy)) @(negedge clk);
  endtask

  task automatic issue_sqrt(fp_word_t a, frm_t rm);
    wait_free(1'b1, 1'b0);
    @(posedge clk);
    sqrt_start <= 1'b1;
    sqrt_a     <= a;
    frm        <= rm;
    exp_sqrt.push_back({UNIT_SQRT, ref_sqrt(a, rm)});
    @(posedge clk);
    sqrt_start <= 1'b0;
  endtask

  task automatic issue_div(fp_word_t a, fp_word_t b, frm_t rm);
    wait_free(1'b0, 1'b1);
    @(posedge clk);
    div_start <= 1'b1;
    div_a     <= a;
    div_b     <= b;
    frm       <= rm;
    exp_div.push_back({UNIT_DIV, ref_div(a, b, rm)});
    @(posedge clk);
    div_start <= 1'b0;
  endtask

  // Both units start on the same edge
  task automatic issue_pair(fp_word_t sa, fp_word_t da, fp_word_t db, frm_t rm);
    wait_free(1'b1, 1'b1);
    @(posedge clk);
    sqrt_start <= 1'b1;
    div_start  <= 1'b1;
    sqrt_a     <= sa;
    div_a      <= da;
    div_b      <= db;
    frm        <= rm;
    exp_sqrt.push_back({UNIT_SQRT, ref_sqrt(sa, rm)});
    exp_div.push_back({UNIT_DIV, ref_div(da, db, rm)});
    @(posedge clk);
    sqrt_start <= 1'b0;
    div_start  <= 1'b0;
  endtask

  // Start pulse into a running unit, nothing expected back
  task automatic pulse_while_busy(unit_id_t u);
    @(negedge clk);
    if ((u == UNIT_DIV) ? !div_busy : !sqrt_busy) begin
      $display("unit %0d not busy right after a start", u);
      stop_run();
    end
    @(posedge clk);
    if (u == UNIT_DIV) div_start <= 1'b1;
    else               sqrt_start <= 1'b1;
    sqrt_a <= 32'h4080_0000;
    div_a  <= 32'h4080_0000;
    @(posedge clk);
    sqrt_start <= 1'b0;
    div_start  <= 1'b0;
  endtask

  // ==============================
  // Writeback compare
  // ==============================
  // Owner of the result is found from the outstanding work, not from the tag
  always @(negedge clk) begin
    if (reset_n && wb_valid) begin
      if (exp_div.size() == 0 && exp_sqrt.size() == 0) begin
        $display("writeback from unit %0d at %0t with no operation outstanding", wb_unit, $time);
        stop_run();
      end else begin
        div_hit  = (exp_div.size() != 0) && (exp_div[0][36:0] == {wb_flags, wb_data});
        sqrt_hit = (exp_sqrt.size() != 0) && (exp_sqrt[0][36:0] == {wb_flags, wb_data});
        if (exp_sqrt.size() == 0)  want = exp_div.pop_front();
        else if (exp_div.size() == 0) want = exp_sqrt.pop_front();
        else if (div_hit && !sqrt_hit) want = exp_div.pop_front();
        else if (sqrt_hit && !div_hit) want = exp_sqrt.pop_front();
        else if (wb_unit == UNIT_DIV) want = exp_div.pop_front();   // Both or neither match
        else                          want = exp_sqrt.pop_front();
        check_unit(wb_unit, want[37:37], "writeback tag");
        check_flags(wb_flags, want[36:32], want[37] ? "div flags" : "sqrt flags");
        check_word(wb_data, want[31:0], want[37] ? "div result" : "sqrt result");
      end
    end
  end

  initial begin
    #(WATCH_TIME);
    $display("timeout: results did not arrive, %0d sqrt and %0d div still pending",
             exp_sqrt.size(), exp_div.size());
    stop_run();
  end

  // ==============================
  // Stimulus
  // ==============================
  initial begin
    seed       = 32'h62ce;
    clk        = 1'b0;
    reset_n    = 1'b0;
    frm        = FRM_RNE;
    sqrt_start = 1'b0;
    div_start  = 1'b0;
    sqrt_a     = '0;
    div_a      = '0;
    div_b      = '0;
    repeat (8) @(posedge clk);
    reset_n <= 1'b1;

    repeat (4) begin                      // Quiet until the first start
      @(negedge clk);
      if (wb_valid || sqrt_busy || div_busy) begin
        $display("activity after reset before any start");
        stop_run();
      end
    end

    repeat (200) issue_sqrt(rand_normal(1'b0), FRM_RNE);

    for (mi = 0; mi < 5; mi++) begin      // Every rounding mode
      repeat (100) begin
        issue_sqrt(rand_normal(1'b0), frm_t'(mi));
        issue_div(rand_normal(1'b1), rand_normal(1'b1), frm_t'(mi));
      end
      issue_sqrt(32'h3F7F_FFFF, frm_t'(mi));  // Rounds up into the exponent
      issue_sqrt(32'h407F_FFFF, frm_t'(mi));
      issue_div(32'h3F80_0000, 32'h3F80_0001, frm_t'(mi));
      issue_div(32'h3FFF_FFFF, 32'h3F80_0001, frm_t'(mi));
    end

    for (k = 0; k < 8; k++) issue_sqrt(SQRT_SPECIAL[k], FRM_RNE);
    for (k = 0; k < 8; k++) issue_div(DIV_SPECIAL_A[k], DIV_SPECIAL_B[k], FRM_RNE);

    for (mi = 0; mi < 5; mi++) begin      // Overflow and underflow per mode and sign
      for (sg = 0; sg < 2; sg++) begin
        issue_div({1'(sg), 8'hFE, 23'h0}, 32'h0080_0000, frm_t'(mi));
        issue_div({1'(sg), 8'h01, 23'h0}, 32'h7F00_0000, frm_t'(mi));
      end
      issue_div(32'h7F7F_FFFF, 32'h3F7F_FFFF, frm_t'(mi));
    end

    repeat (50) issue_pair(rand_normal(1'b0), rand_normal(1'b1), rand_normal(1'b1), FRM_RNE);
    repeat (50) begin                     // Staggered starts
      issue_sqrt(rand_normal(1'b0), FRM_RMM);
      off = $unsigned($random(seed)) % 40;
      repeat (off) @(posedge clk);
      issue_div(rand_normal(1'b1), rand_normal(1'b1), FRM_RMM);
    end

    issue_sqrt(32'h4110_0000, FRM_RNE);
    pulse_while_busy(UNIT_SQRT);
    issue_div(32'h4110_0000, 32'h4040_0000, FRM_RNE);
    pulse_while_busy(UNIT_DIV);

    while (exp_sqrt.size() != 0 || exp_div.size() != 0) @(negedge clk);
    wait_free(1'b1, 1'b1);
    repeat (10) @(negedge clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: all.f
+incdir+sim
hw/fpu_pkg.sv
hw/fp_sqrt.sv
hw/fp_div.sv
hw/wb_arbiter.sv
hw/fpu_iter_top.sv
sim/tb_fpu_iter.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the FPU iterative-unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -f all.f --top-module tb_fpu_iter --Mdir obj_dir -o tb_fpu_iter
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_fpu_iter
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
fi
exit $status
